// ==== compile.f ====
+incdir+hdl
hdl/congestion_pkg.sv
hdl/congestion_level_gen.sv
hdl/port_presel_gen.sv
hdl/deadlock_detector.sv
hdl/congestion_analyzer.sv
verif/congestion_asserts.sv
verif/congestion_monitor.sv
verif/tb_congestion_analyzer.sv

// ==== verif/tb_congestion_analyzer.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module tb_congestion_analyzer;
    import congestion_pkg::*;

    typedef struct {
        ivc_vec_t    req;
        ivc_vec_t    gnt;
        cong_all_t   cin;
        int          hold;          // cycles the row stays on the inputs
        bit          rnd;           // fresh random vectors every cycle
        logic [2:0]  mask;          // bit0 level, bit1 presel, bit2 deadlock
        cong_level_t lvl;
        presel_t     psel;
        logic        dl;
    } row_t;

    logic        clk;
    logic        rst_n;
    ivc_vec_t    ivc_request_all;
    ivc_vec_t    ivc_grant_all;
    cong_all_t   congestion_in_all;
    cong_all_t   congestion_out_all;
    presel_t     port_pre_sel;
    logic        deadlock_detect;
    logic [2:0]  exp_mask;
    cong_level_t exp_lvl;
    presel_t     exp_psel;
    logic        exp_dl;
    int          mon_errors;
    int          seed = 32'h67885923;
    int          total_hold;
    row_t        rows [$];

    always #50 clk = ~clk;

    congestion_analyzer u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .ivc_request_all    (ivc_request_all),
        .ivc_grant_all      (ivc_grant_all),
        .congestion_in_all  (congestion_in_all),
        .congestion_out_all (congestion_out_all),
        .port_pre_sel       (port_pre_sel),
        .deadlock_detect    (deadlock_detect)
    );

    congestion_monitor u_mon (
        .clk                (clk),
        .rst_n              (rst_n),
        .ivc_request_all    (ivc_request_all),
        .ivc_grant_all      (ivc_grant_all),
        .congestion_in_all  (congestion_in_all),
        .congestion_out_all (congestion_out_all),
        .port_pre_sel       (port_pre_sel),
        .deadlock_detect    (deadlock_detect),
        .exp_mask           (exp_mask),
        .exp_lvl            (exp_lvl),
        .exp_psel           (exp_psel),
        .exp_dl             (exp_dl),
        .error_count        (mon_errors)
    );

    function automatic void add_row(input ivc_vec_t req, input ivc_vec_t gnt,
                                    input cong_all_t cin, input int hold, input bit rnd,
                                    input logic [2:0] mask, input cong_level_t lvl,
                                    input presel_t psel, input logic dl);
        row_t r;
        r.req  = req;
        r.gnt  = gnt;
        r.cin  = cin;
        r.hold = hold;
        r.rnd  = rnd;
        r.mask = mask;
        r.lvl  = lvl;
        r.psel = psel;
        r.dl   = dl;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row(20'h00000, 20'h00000, 10'h000, 4, 0, 3'b111, 2'd0, 4'h0, 0);    // quiet after reset
        // not-granted counts 0 2 3 4 5 10 11 20
        add_row(20'hFFFFF, 20'hFFFFF, 10'h000, 3, 0, 3'b011, 2'd0, 4'h0, 0);
        add_row(20'h00003, 20'h00000, 10'h000, 3, 0, 3'b011, 2'd0, 4'h0, 0);
        add_row(20'h000FF, 20'h000F8, 10'h000, 3, 0, 3'b011, 2'd1, 4'h0, 0);
        add_row(20'h0000F, 20'h00000, 10'h000, 3, 0, 3'b011, 2'd1, 4'h0, 0);
        add_row(20'h0001F, 20'h00000, 10'h000, 3, 0, 3'b011, 2'd2, 4'h0, 0);
        add_row(20'h003FF, 20'h00000, 10'h000, 3, 0, 3'b011, 2'd2, 4'h0, 0);
        add_row(20'hFFFFF, 20'hFF800, 10'h000, 3, 0, 3'b011, 2'd3, 4'h0, 0);
        add_row(20'hFFFFF, 20'h00000, 10'h000, 3, 0, 3'b011, 2'd3, 4'h0, 0);
        // neighbour levels, slots local east north west south from bit 0
        add_row(20'h00000, 20'h00000, 10'h21C, 2, 0, 3'b010, 2'd0, 4'hC, 0);
        add_row(20'h00000, 20'h00000, 10'h2AB, 2, 0, 3'b010, 2'd0, 4'h0, 0);    // all ties
        add_row(20'h00000, 20'h00000, 10'h1C1, 2, 0, 3'b010, 2'd0, 4'h3, 0);
        add_row(20'h00000, 20'h00000, 10'h046, 2, 0, 3'b010, 2'd0, 4'hF, 0);
        add_row(20'h00000, 20'h00000, 10'h21F, 2, 0, 3'b010, 2'd0, 4'hC, 0);    // local only changed
        add_row(20'h00000, 20'h00000, 10'h1F8, 2, 0, 3'b010, 2'd0, 4'h5, 0);
        // long stall on vc 0, flag at count 15 then wrap
        add_row(20'h00000, 20'hFFFFF, 10'h000, 2, 0, 3'b000, 2'd0, 4'h0, 0);
        add_row(20'h00010, 20'h00000, 10'h000, 17, 0, 3'b111, 2'd0, 4'h0, 1);
        add_row(20'h00010, 20'h00000, 10'h000, 2, 0, 3'b110, 2'd0, 4'h0, 0);
        // stall on vc 1 under vc 2 grants, then a vc 1 grant from port 4
        add_row(20'h00000, 20'hFFFFF, 10'h000, 2, 0, 3'b000, 2'd0, 4'h0, 0);
        add_row(20'h00020, 20'h00040, 10'h000, 17, 0, 3'b111, 2'd0, 4'h0, 1);
        add_row(20'h00020, 20'h00000, 10'h000, 11, 0, 3'b000, 2'd0, 4'h0, 0);
        add_row(20'h00020, 20'h20000, 10'h000, 1, 0, 3'b000, 2'd0, 4'h0, 0);
        add_row(20'h00020, 20'h00000, 10'h000, 17, 0, 3'b111, 2'd0, 4'h0, 1);
        add_row(20'h00000, 20'h00000, 10'h000, 60, 1, 3'b000, 2'd0, 4'h0, 0);
    endfunction

    task automatic drive_random();
        logic [31:0] word;
        logic [31:0] sparse;
        word = $random(seed);
        ivc_request_all = word[`CA_PV-1:0];
        word   = $random(seed);
        sparse = $random(seed);
        ivc_grant_all = word[`CA_PV-1:0] & sparse[`CA_PV-1:0] & ivc_request_all;
        word = $random(seed);
        congestion_in_all = word[`CA_P*`CA_CONGW-1:0];
    endtask

    task automatic apply_row(input row_t r);
        if (r.rnd) begin
            repeat (r.hold) begin
                drive_random();
                @(posedge clk);
                #1;
            end
        end else begin
            ivc_request_all   = r.req;
            ivc_grant_all     = r.gnt;
            congestion_in_all = r.cin;
            repeat (r.hold - 1) begin
                @(posedge clk);
                #1;
            end
            exp_mask = r.mask;      // last cycle of the row
            exp_lvl  = r.lvl;
            exp_psel = r.psel;
            exp_dl   = r.dl;
            @(posedge clk);
            #1;
            exp_mask = 3'b000;
        end
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        ivc_request_all   = '0;
        ivc_grant_all     = '0;
        congestion_in_all = '0;
        exp_mask          = 3'b000;
        exp_lvl           = '0;
        exp_psel          = '0;
        exp_dl            = 1'b0;
        build_table();
        total_hold = 0;
        foreach (rows[i]) total_hold += rows[i].hold;
        fork
            begin
                #((16 + total_hold + 20) * 100);
                $display("timeout: the stimulus table did not finish in time");
                $display("Test FAILED");
                $finish;
            end
        join_none
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) apply_row(rows[i]);
        repeat (2) @(posedge clk);
        #1;
        $display("errors: %0d from the checker, %0d from assertions",
                 mon_errors, u_dut.u_asserts.assert_errors);
        if (mon_errors == 0 && u_dut.u_asserts.assert_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/congestion_monitor.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module congestion_monitor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  congestion_pkg::ivc_vec_t    ivc_request_all,
    input  congestion_pkg::ivc_vec_t    ivc_grant_all,
    input  congestion_pkg::cong_all_t   congestion_in_all,
    input  congestion_pkg::cong_all_t   congestion_out_all,
    input  congestion_pkg::presel_t     port_pre_sel,
    input  logic                        deadlock_detect,
    input  logic [2:0]                  exp_mask,     // table checks, level presel deadlock
    input  congestion_pkg::cong_level_t exp_lvl,
    input  congestion_pkg::presel_t     exp_psel,
    input  logic                        exp_dl,
    output int                          error_count
);
    import congestion_pkg::*;

    ivc_vec_t    ng_q;              // model of the request minus grant stage
    ivc_vec_t    gnt_q;
    cong_level_t lvl_q;
    presel_t     psel_q;
    logic [`CA_CNTW-1:0] cnt [4];   // stall counter per vc index
    logic        armed = 1'b0;
    int          errors = 0;

    assign error_count = errors;

    function automatic cong_level_t level_of(input ivc_vec_t v);
        int n;
        n = 0;
        for (int i = 0; i < 20; i++) begin
            if (v[i]) n++;
        end
        if (n <= 2) return 2'd0;    // tenth of 20
        if (n <= 4) return 2'd1;    // fifth
        if (n <= 10) return 2'd2;   // half
        return 2'd3;
    endfunction

    function automatic presel_t presel_of(input cong_all_t c);
        cong_level_t e;
        cong_level_t n;
        cong_level_t w;
        cong_level_t s;
        presel_t     p;
        e = c[3:2];
        n = c[5:4];
        w = c[7:6];
        s = c[9:8];
        p[3] = (e > n);
        p[2] = (e > s);
        p[1] = (w > n);
        p[0] = (w > s);
        return p;
    endfunction

    function automatic logic any_port(input ivc_vec_t v, input int vc);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < 5; j++) begin
            hit = hit | v[j*4+vc];
        end
        return hit;
    endfunction

    function automatic logic dl_of();
        logic hit;
        hit = 1'b0;
        for (int v = 0; v < 4; v++) begin
            hit = hit | (cnt[v] == 4'd15);
        end
        return hit;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ng_q   <= '0;
            gnt_q  <= '0;
            lvl_q  <= '0;
            psel_q <= '0;
            for (int v = 0; v < 4; v++) begin
                cnt[v] <= 4'd0;
            end
            armed <= 1'b1;
        end else begin
            for (int v = 0; v < 4; v++) begin
                if (any_port(gnt_q, v)) begin
                    cnt[v] <= 4'd0;
                end else if (any_port(ivc_request_all, v)) begin
                    cnt[v] <= cnt[v] + 4'd1;    // 15 wraps to 0
                end
            end
            gnt_q  <= ivc_grant_all;
            ng_q   <= ivc_request_all & ~ivc_grant_all;
            lvl_q  <= level_of(ng_q);
            psel_q <= presel_of(congestion_in_all);
        end
    end

    // outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (armed) begin
            compare("congestion_out_all", 32'(congestion_out_all), 32'({5{lvl_q}}));
            compare("port_pre_sel", 32'(port_pre_sel), 32'(psel_q));
            compare("deadlock_detect", 32'(deadlock_detect), 32'(dl_of()));
            if (exp_mask[0]) begin
                compare("congestion_out_all (table)", 32'(congestion_out_all), 32'({5{exp_lvl}}));
            end
            if (exp_mask[1]) begin
                compare("port_pre_sel (table)", 32'(port_pre_sel), 32'(exp_psel));
            end
            if (exp_mask[2]) begin
                compare("deadlock_detect (table)", 32'(deadlock_detect), 32'(exp_dl));
            end
        end
    end

endmodule

// ==== verif/congestion_asserts.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module congestion_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input congestion_pkg::ivc_vec_t  ivc_request_all,
    input congestion_pkg::cong_all_t congestion_out_all,
    input congestion_pkg::presel_t   port_pre_sel,
    input logic                      deadlock_detect
);
    import congestion_pkg::*;

    int assert_errors = 0;      // read by the testbench at the end

    // registers are cleared one edge into reset
    reset_clears_outputs: assert property (@(posedge clk)
        !rst_n |=> (congestion_out_all == '0 && port_pre_sel == '0 && !deadlock_detect))
    else begin
        $error("outputs are not zero in the cycle after a reset edge");
        assert_errors++;
    end

    // own level is replicated to every port slot
    slots_equal: assert property (@(posedge clk) disable iff (!rst_n)
        congestion_out_all == {`CA_P{congestion_out_all[`CA_CONGW-1:0]}})
    else begin
        $error("congestion output slots do not carry the same level");
        assert_errors++;
    end

    // a counter only reaches the limit by counting a request
    deadlock_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(deadlock_detect) |-> $past(|ivc_request_all))
    else begin
        $error("deadlock flag rose without a request in the previous cycle");
        assert_errors++;
    end

endmodule

bind congestion_analyzer congestion_asserts u_asserts (
    .clk                (clk),
    .rst_n              (rst_n),
    .ivc_request_all    (ivc_request_all),
    .congestion_out_all (congestion_out_all),
    .port_pre_sel       (port_pre_sel),
    .deadlock_detect    (deadlock_detect)
);

// ==== hdl/congestion_analyzer.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module congestion_analyzer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::ivc_vec_t  ivc_request_all,    // switch requests, all ivcs
    input  congestion_pkg::ivc_vec_t  ivc_grant_all,      // switch grants, all ivcs
    input  congestion_pkg::cong_all_t congestion_in_all,  // levels from the neighbours
    output congestion_pkg::cong_all_t congestion_out_all,
    output congestion_pkg::presel_t   port_pre_sel,
    output logic                      deadlock_detect
);

    // own congestion, from requests that lose arbitration
    congestion_level_gen u_level_gen (
        .clk                (clk),
        .rst_n              (rst_n),
        .ivc_request_all    (ivc_request_all),
        .ivc_grant_all      (ivc_grant_all),
        .congestion_out_all (congestion_out_all)
    );

    // x or y preference per quadrant from neighbour levels
    port_pre_sel_gen u_presel_gen (
        .clk               (clk),
        .rst_n             (rst_n),
        .congestion_in_all (congestion_in_all),
        .port_pre_sel      (port_pre_sel)
    );

    // stall watch per vc
    deadlock_detector #(
        .MAX_CLK (`CA_MAX_CLK)
    ) u_deadlock (
        .clk             (clk),
        .rst_n           (rst_n),
        .ivc_request_all (ivc_request_all),
        .ivc_grant_all   (ivc_grant_all),
        .deadlock_detect (deadlock_detect)
    );

endmodule

// ==== hdl/deadlock_detector.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module deadlock_detector #(
    parameter int MAX_CLK = `CA_MAX_CLK
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  congestion_pkg::ivc_vec_t ivc_request_all,
    input  congestion_pkg::ivc_vec_t ivc_grant_all,
    output logic                     deadlock_detect
);
    import congestion_pkg::*;

    localparam int CNTW = (MAX_CLK > 1) ? $clog2(MAX_CLK) : 1;
    localparam logic [CNTW-1:0] LIMIT = CNTW'(MAX_CLK - 1);

    ivc_vec_t        grant_q;
    logic [`CA_V-1:0] vc_clear;     // some port got a grant on this vc
    logic [`CA_V-1:0] vc_stall;     // some port is asking on this vc
    logic [`CA_V-1:0] vc_hit;
    logic [CNTW-1:0]  stall_cnt [`CA_V];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= '0;
        end else begin
            grant_q <= ivc_grant_all;
        end
    end

    // fold all ports onto the vc index
    always_comb begin
        vc_clear = '0;
        vc_stall = '0;
        for (int i = 0; i < `CA_V; i++) begin
            for (int j = 0; j < `CA_P; j++) begin
                vc_clear[i] = vc_clear[i] | grant_q[j*`CA_V+i];
                vc_stall[i] = vc_stall[i] | ivc_request_all[j*`CA_V+i];
            end
        end
    end

    // a grant wins over a request in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CA_V; i++) begin
                stall_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `CA_V; i++) begin
                if (vc_clear[i]) begin
                    stall_cnt[i] <= '0;
                end else if (vc_stall[i]) begin
                    stall_cnt[i] <= stall_cnt[i] + 1'b1;    // wraps at full scale
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `CA_V; i++) begin
            vc_hit[i] = (stall_cnt[i] == LIMIT);
        end
    end

    assign deadlock_detect = |vc_hit;

endmodule

// ==== hdl/port_presel_gen.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module port_pre_sel_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::cong_all_t congestion_in_all,
    output congestion_pkg::presel_t   port_pre_sel
);
    import congestion_pkg::*;

    localparam logic XDIR = 1'b0;
    localparam logic YDIR = 1'b1;

    cong_level_t nb_level [4];      // indexed by port_dir_e
    presel_t     presel_d;
    presel_t     presel_q;

    // y is taken only when x is strictly worse, ties stay on x
    function automatic logic pick_dir(input cong_level_t x_lvl, input cong_level_t y_lvl);
        return (x_lvl > y_lvl) ? YDIR : XDIR;
    endfunction

    // neighbour slots start at 1, local slot is not looked at
    always_comb begin
        for (int d = 0; d < 4; d++) begin
            nb_level[d] = congestion_in_all[(d+1)*`CA_CONGW +: `CA_CONGW];
        end
    end

    /*
     *       north
     *    Q1   |   Q3
     *  west --+-- east
     *    Q0   |   Q2
     *       south
     */
    always_comb begin
        presel_d          = '0;
        presel_d[Q_XP_YP] = pick_dir(nb_level[DIR_EAST], nb_level[DIR_NORTH]);
        presel_d[Q_XM_YP] = pick_dir(nb_level[DIR_WEST], nb_level[DIR_NORTH]);
        presel_d[Q_XP_YM] = pick_dir(nb_level[DIR_EAST], nb_level[DIR_SOUTH]);
        presel_d[Q_XM_YM] = pick_dir(nb_level[DIR_WEST], nb_level[DIR_SOUTH]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presel_q <= '0;
        end else begin
            presel_q <= presel_d;
        end
    end

    assign port_pre_sel = presel_q;

endmodule

// ==== hdl/congestion_level_gen.sv ====
`timescale 1ns/1ps
`include "congestion_defs.svh"

module congestion_level_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  congestion_pkg::ivc_vec_t  ivc_request_all,
    input  congestion_pkg::ivc_vec_t  ivc_grant_all,
    output congestion_pkg::cong_all_t congestion_out_all
);
    import congestion_pkg::*;

    // level thresholds as fractions of all input vcs
    localparam int TH_TENTH = `CA_PV / 10;
    localparam int TH_FIFTH = `CA_PV / 5;
    localparam int TH_HALF  = `CA_PV / 2;

    ivc_vec_t    not_granted_q;     // requests left waiting last cycle
    ivc_cnt_t    stall_num;
    cong_level_t level_d;
    cong_level_t level_q;

    // first stage, capture who asked and lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            not_granted_q <= '0;
        end else begin
            not_granted_q <= ivc_request_all & ~ivc_grant_all;
        end
    end

    assign stall_num = count_ones(not_granted_q);

    always_comb begin
        if (stall_num <= TH_TENTH) begin
            level_d = 2'd0;             // 0..10 %
        end else if (stall_num <= TH_FIFTH) begin
            level_d = 2'd1;             // up to 20 %
        end else if (stall_num <= TH_HALF) begin
            level_d = 2'd2;             // up to 50 %
        end else begin
            level_d = 2'd3;
        end
    end

    // second stage, level goes out on the next edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= '0;
        end else begin
            level_q <= level_d;
        end
    end

    // the router reports one level, same value to every neighbour
    assign congestion_out_all = {`CA_P{level_q}};

endmodule

// ==== hdl/congestion_pkg.sv ====
`include "congestion_defs.svh"

package congestion_pkg;

    // one bit per input vc, bit j*V+i is port j vc i
    typedef logic [`CA_PV-1:0] ivc_vec_t;

    // number of set bits in an ivc vector, 0..CA_PV
    typedef logic [$clog2(`CA_PV+1)-1:0] ivc_cnt_t;

    // 0 least congested, 3 most congested
    typedef logic [`CA_CONGW-1:0] cong_level_t;

    // one level slot per port, slot 0 is local
    typedef logic [`CA_P*`CA_CONGW-1:0] cong_all_t;

    // one bit per quadrant, 0 prefers x and 1 prefers y
    typedef logic [3:0] presel_t;

    // neighbour directions, slot index minus one
    typedef enum logic [1:0] {
        DIR_EAST  = 2'd0,
        DIR_NORTH = 2'd1,
        DIR_WEST  = 2'd2,
        DIR_SOUTH = 2'd3
    } port_dir_e;

    typedef enum logic [1:0] {
        Q_XM_YM = 2'd0,
        Q_XM_YP = 2'd1,
        Q_XP_YM = 2'd2,
        Q_XP_YP = 2'd3
    } quadrant_e;

    function automatic ivc_cnt_t count_ones(input ivc_vec_t vec);
        ivc_cnt_t sum;
        sum = '0;
        for (int i = 0; i < `CA_PV; i++) begin
            sum = sum + ivc_cnt_t'(vec[i]);
        end
        return sum;
    endfunction

endpackage

// ==== hdl/congestion_defs.svh ====
`ifndef CONGESTION_DEFS_SVH
`define CONGESTION_DEFS_SVH

// router geometry
`define CA_P        5                   // local, east, north, west, south
`define CA_V        4                   // vcs per port
`define CA_PV       (`CA_P * `CA_V)     // all input vcs

// congestion level carried per port slot
`define CA_CONGW    2

// deadlock watch
`define CA_MAX_CLK  16                  // stall cycles before the flag
`define CA_CNTW     4                   // counter width for the default limit

`endif
